//--- Makefile
# Verilator build and run for the DDR read port controller

VERILATOR ?= verilator
TOP       ?= tb_rd_ddr_port_ctrl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard logic/*.sv logic/*.svh tests/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -qx "Test passed" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/ddr_rd_pkg.sv
package ddr_rd_pkg;

    `include "ddr_rd_settings.svh"

    // Transmit round states
    typedef enum logic [2:0] {
        TX_IDLE     = 3'd0,
        TX_UNLOCAL  = 3'd1,
        TX_MY_TWO   = 3'd2,
        TX_RECV_TWO = 3'd3,
        TX_LOCAL    = 3'd4,
        TX_RELAY    = 3'd5
    } tx_state_e;

    typedef logic [`DDR_RD_SIZE_W-1:0] byte_cnt_t;

    typedef logic [`DDR_RD_QUEUE_W-1:0] queue_t;

    // Queue 0 sits in the low bits
    typedef logic [`DDR_RD_QUEUE_NUM*`DDR_RD_SIZE_W-1:0] relay_sizes_t;

endpackage

//--- logic/ddr_rd_settings.svh
`ifndef DDR_RD_SETTINGS_SVH
`define DDR_RD_SETTINGS_SVH

// Byte count width of one read request
`define DDR_RD_SIZE_W 32

// Relay queues and the width of a queue number
`define DDR_RD_QUEUE_NUM 8
`define DDR_RD_QUEUE_W 3

// Synchronizer depths for the asynchronous read-side levels
`define DDR_RD_READY_SYNC 3
`define DDR_RD_FINISH_SYNC 2

`endif

//--- logic/edge_sync.sv
`timescale 1ns/1ps

module edge_sync #(
    parameter int STAGES = 2
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_level,
    output logic o_rise
);

    logic [STAGES-1:0] r_sync;

    // Oldest sample sits in the top bit
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_sync <= '0;
        end else begin
            r_sync <= {r_sync[STAGES-2:0], i_level};
        end
    end

    // One-cycle pulse on a low to high change between the last two stages
    assign o_rise = r_sync[STAGES-2] & ~r_sync[STAGES-1];

endmodule

//--- logic/rd_ddr_port_ctrl.sv
`timescale 1ns/1ps

`include "ddr_rd_settings.svh"

module rd_ddr_port_ctrl import ddr_rd_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,

    input  logic         i_unlocal_valid,
    input  byte_cnt_t    i_unlocal_size,
    input  queue_t       i_unlocal_queue,
    input  logic         i_send_local2_valid,
    input  byte_cnt_t    i_send_local2_size,
    input  queue_t       i_send_local2_queue,
    input  logic         i_local_direct_valid,
    input  byte_cnt_t    i_local_direct_size,
    input  queue_t       i_local_direct_queue,
    input  logic         i_recv_local2_valid,
    input  byte_cnt_t    i_recv_local2_size,
    input  relay_sizes_t i_tx_relay,
    input  logic         i_tx_relay_valid,

    output logic         o_rd_flag,
    output queue_t       o_rd_queue,
    output byte_cnt_t    o_rd_byte,
    output logic         o_rd_byte_valid,
    input  logic         i_rd_byte_ready,
    input  logic         i_rd_queue_finish,

    input  logic         i_forward_req,
    output logic         o_forward_resp,
    input  logic         i_forward_finish,
    output logic         o_forward_valid
);

    logic      ready_pulse;
    logic      finish_pulse;
    logic      src_pending;
    queue_t    src_queue;
    byte_cnt_t src_size;
    logic      src_remote;
    logic      round_idle;
    logic      relay_active;
    logic      relay_pending_any;
    queue_t    relay_queue;
    byte_cnt_t relay_size;
    logic      relay_done;

    //////////////////////////////////////////////////////////////////////
    // Read-side levels into the clock domain

    edge_sync #(
        .STAGES (`DDR_RD_READY_SYNC)
    ) u_ready_sync (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_level (i_rd_byte_ready),
        .o_rise  (ready_pulse)
    );

    edge_sync #(
        .STAGES (`DDR_RD_FINISH_SYNC)
    ) u_finish_sync (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_level (i_rd_queue_finish),
        .o_rise  (finish_pulse)
    );

    //////////////////////////////////////////////////////////////////////
    // Round control, relay queues and request output

    tx_round_fsm u_tx_round_fsm (
        .i_clk                (i_clk),
        .i_rst                (i_rst),
        .i_unlocal_valid      (i_unlocal_valid),
        .i_unlocal_size       (i_unlocal_size),
        .i_unlocal_queue      (i_unlocal_queue),
        .i_send_local2_valid  (i_send_local2_valid),
        .i_send_local2_size   (i_send_local2_size),
        .i_send_local2_queue  (i_send_local2_queue),
        .i_local_direct_valid (i_local_direct_valid),
        .i_local_direct_size  (i_local_direct_size),
        .i_local_direct_queue (i_local_direct_queue),
        .i_recv_local2_valid  (i_recv_local2_valid),
        .i_recv_local2_size   (i_recv_local2_size),
        .i_finish_pulse       (finish_pulse),
        .i_forward_req        (i_forward_req),
        .i_forward_finish     (i_forward_finish),
        .i_relay_pending_any  (relay_pending_any),
        .i_relay_queue        (relay_queue),
        .i_relay_size         (relay_size),
        .i_relay_done         (relay_done),
        .o_src_pending        (src_pending),
        .o_src_queue          (src_queue),
        .o_src_size           (src_size),
        .o_src_remote         (src_remote),
        .o_round_idle         (round_idle),
        .o_relay_active       (relay_active),
        .o_forward_resp       (o_forward_resp),
        .o_forward_valid      (o_forward_valid)
    );

    relay_queue_tracker u_relay_queue_tracker (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .i_tx_relay          (i_tx_relay),
        .i_tx_relay_valid    (i_tx_relay_valid),
        .i_relay_active      (relay_active),
        .i_finish_pulse      (finish_pulse),
        .o_relay_queue       (relay_queue),
        .o_relay_size        (relay_size),
        .o_relay_pending_any (relay_pending_any),
        .o_relay_done        (relay_done)
    );

    rd_req_issuer u_rd_req_issuer (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_src_pending   (src_pending),
        .i_src_queue     (src_queue),
        .i_src_size      (src_size),
        .i_src_remote    (src_remote),
        .i_round_idle    (round_idle),
        .i_ready_pulse   (ready_pulse),
        .i_finish_pulse  (finish_pulse),
        .o_rd_flag       (o_rd_flag),
        .o_rd_queue      (o_rd_queue),
        .o_rd_byte       (o_rd_byte),
        .o_rd_byte_valid (o_rd_byte_valid)
    );

endmodule

//--- logic/rd_req_issuer.sv
`timescale 1ns/1ps

module rd_req_issuer import ddr_rd_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_src_pending,
    input  queue_t    i_src_queue,
    input  byte_cnt_t i_src_size,
    input  logic      i_src_remote,
    input  logic      i_round_idle,
    input  logic      i_ready_pulse,
    input  logic      i_finish_pulse,
    output logic      o_rd_flag,
    output queue_t    o_rd_queue,
    output byte_cnt_t o_rd_byte,
    output logic      o_rd_byte_valid
);

    logic r_ddr_lock;
    logic accept;
    logic issue;

    // Memory side took the request
    assign accept = o_rd_byte_valid && i_ready_pulse;

    assign issue = i_src_pending && !r_ddr_lock && !o_rd_byte_valid;

    //////////////////////////////////////////////////////////////////////
    // Request registers

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_rd_flag       <= 1'b0;
            o_rd_queue      <= '0;
            o_rd_byte       <= '0;
            o_rd_byte_valid <= 1'b0;
        end else if (accept) begin
            // Fields stay put for the memory side
            o_rd_byte_valid <= 1'b0;
        end else if (i_round_idle) begin
            o_rd_flag       <= 1'b0;
            o_rd_queue      <= '0;
            o_rd_byte       <= '0;
            o_rd_byte_valid <= 1'b0;
        end else if (issue) begin
            o_rd_flag       <= i_src_remote;
            o_rd_queue      <= i_src_queue;
            o_rd_byte       <= i_src_size;
            o_rd_byte_valid <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // DDR lock for the one read in flight

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_ddr_lock <= 1'b0;
        end else if (i_finish_pulse) begin
            r_ddr_lock <= 1'b0;
        end else if (o_rd_byte_valid) begin
            r_ddr_lock <= 1'b1;
        end
    end

endmodule

//--- logic/relay_queue_tracker.sv
`timescale 1ns/1ps

`include "ddr_rd_settings.svh"

module relay_queue_tracker import ddr_rd_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst,
    input  relay_sizes_t i_tx_relay,
    input  logic         i_tx_relay_valid,
    input  logic         i_relay_active,
    input  logic         i_finish_pulse,
    output queue_t       o_relay_queue,
    output byte_cnt_t    o_relay_size,
    output logic         o_relay_pending_any,
    output logic         o_relay_done
);

    localparam int QN = `DDR_RD_QUEUE_NUM;
    localparam int SW = `DDR_RD_SIZE_W;

    relay_sizes_t  r_sizes;
    logic          r_valid;
    logic          r_valid_1d;
    logic [QN-1:0] r_pending;
    logic [QN-1:0] lowest;
    logic [QN-1:0] nonzero;
    logic          clear_all;

    assign clear_all = i_relay_active && o_relay_done;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_sizes    <= '0;
            r_valid    <= 1'b0;
            r_valid_1d <= 1'b0;
        end else if (clear_all) begin
            r_sizes    <= '0;
            r_valid    <= 1'b0;
            r_valid_1d <= 1'b0;
        end else begin
            if (i_tx_relay_valid) begin
                r_sizes <= i_tx_relay;
                r_valid <= 1'b1;
            end
            r_valid_1d <= r_valid;
        end
    end

    always_comb begin
        for (int i = 0; i < QN; i++)
            nonzero[i] = (r_sizes[i*SW +: SW] != '0);
    end

    // Isolate the lowest set bit
    assign lowest = r_pending & (~r_pending + 1'b1);

    //////////////////////////////////////////////////////////////////////
    // Pending bits armed once per capture

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_pending <= '0;
        end else if (clear_all) begin
            r_pending <= '0;
        end else if (r_valid && !r_valid_1d) begin
            r_pending <= nonzero;
        end else if (i_relay_active && i_finish_pulse) begin
            r_pending <= r_pending & ~lowest;
        end
    end

    // Lowest pending queue wins
    always_comb begin
        o_relay_queue = '0;
        for (int i = QN - 1; i >= 0; i--) begin
            if (r_pending[i])
                o_relay_queue = queue_t'(i);
        end
    end

    assign o_relay_size        = r_sizes[o_relay_queue*SW +: SW];
    assign o_relay_pending_any = |r_pending;

    // Either nothing to relay, or every pending queue has been served
    assign o_relay_done = (r_valid && r_sizes == '0) ||
                          (r_valid_1d && r_pending == '0);

endmodule

//--- logic/tx_round_fsm.sv
`timescale 1ns/1ps

module tx_round_fsm import ddr_rd_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,

    input  logic      i_unlocal_valid,
    input  byte_cnt_t i_unlocal_size,
    input  queue_t    i_unlocal_queue,
    input  logic      i_send_local2_valid,
    input  byte_cnt_t i_send_local2_size,
    input  queue_t    i_send_local2_queue,
    input  logic      i_local_direct_valid,
    input  byte_cnt_t i_local_direct_size,
    input  queue_t    i_local_direct_queue,
    input  logic      i_recv_local2_valid,
    input  byte_cnt_t i_recv_local2_size,

    input  logic      i_finish_pulse,
    input  logic      i_forward_req,
    input  logic      i_forward_finish,

    input  logic      i_relay_pending_any,
    input  queue_t    i_relay_queue,
    input  byte_cnt_t i_relay_size,
    input  logic      i_relay_done,

    output logic      o_src_pending,
    output queue_t    o_src_queue,
    output byte_cnt_t o_src_size,
    output logic      o_src_remote,
    output logic      o_round_idle,
    output logic      o_relay_active,
    output logic      o_forward_resp,
    output logic      o_forward_valid
);

    tx_state_e r_state;
    tx_state_e next_state;

    logic      r_unlocal_valid;
    byte_cnt_t r_unlocal_size;
    queue_t    r_unlocal_queue;
    logic      r_send_valid;
    byte_cnt_t r_send_size;
    queue_t    r_send_queue;
    logic      r_local_valid;
    byte_cnt_t r_local_size;
    queue_t    r_local_queue;
    logic      r_recv_valid;
    byte_cnt_t r_recv_size;

    //////////////////////////////////////////////////////////////////////
    // Source descriptors

    // Unlocal starts the round and is dropped only once the round moves on
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_unlocal_valid <= 1'b0;
            r_unlocal_size  <= '0;
            r_unlocal_queue <= '0;
        end else if (r_state == TX_MY_TWO) begin
            r_unlocal_valid <= 1'b0;
            r_unlocal_size  <= '0;
            r_unlocal_queue <= '0;
        end else if (i_unlocal_valid) begin
            r_unlocal_valid <= 1'b1;
            r_unlocal_size  <= i_unlocal_size;
            r_unlocal_queue <= i_unlocal_queue;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_send_valid  <= 1'b0;
            r_send_size   <= '0;
            r_send_queue  <= '0;
            r_local_valid <= 1'b0;
            r_local_size  <= '0;
            r_local_queue <= '0;
            r_recv_valid  <= 1'b0;
            r_recv_size   <= '0;
        end else if (r_state == TX_IDLE) begin
            r_send_valid  <= 1'b0;
            r_send_size   <= '0;
            r_send_queue  <= '0;
            r_local_valid <= 1'b0;
            r_local_size  <= '0;
            r_local_queue <= '0;
            r_recv_valid  <= 1'b0;
            r_recv_size   <= '0;
        end else begin
            if (i_send_local2_valid) begin
                r_send_valid <= 1'b1;
                r_send_size  <= i_send_local2_size;
                r_send_queue <= i_send_local2_queue;
            end
            if (i_local_direct_valid) begin
                r_local_valid <= 1'b1;
                r_local_size  <= i_local_direct_size;
                r_local_queue <= i_local_direct_queue;
            end
            if (i_recv_local2_valid) begin
                r_recv_valid <= 1'b1;
                r_recv_size  <= i_recv_local2_size;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Round sequencing

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_state <= TX_IDLE;
        end else begin
            r_state <= next_state;
        end
    end

    always_comb begin
        next_state = r_state;
        case (r_state)
            TX_IDLE: begin
                if (i_unlocal_valid)
                    next_state = TX_UNLOCAL;
            end
            TX_UNLOCAL: begin
                if (i_finish_pulse || (r_unlocal_valid && r_unlocal_size == '0))
                    next_state = TX_MY_TWO;
            end
            TX_MY_TWO: begin
                if (r_send_valid && (r_send_size == '0 || i_finish_pulse))
                    next_state = TX_LOCAL;
            end
            TX_LOCAL: begin
                if (r_local_valid && (r_local_size == '0 || i_finish_pulse))
                    next_state = TX_RECV_TWO;
            end
            // The forward partner reads memory itself
            TX_RECV_TWO: begin
                if (r_recv_valid && (r_recv_size == '0 || i_forward_finish))
                    next_state = TX_RELAY;
            end
            TX_RELAY: begin
                if (i_relay_done)
                    next_state = TX_IDLE;
            end
            default: next_state = TX_IDLE;
        endcase
    end

    // Descriptor of the current state towards the issuer
    always_comb begin
        o_src_pending = 1'b0;
        o_src_queue   = '0;
        o_src_size    = '0;
        case (r_state)
            TX_UNLOCAL: begin
                o_src_pending = r_unlocal_valid && r_unlocal_size != '0;
                o_src_queue   = r_unlocal_queue;
                o_src_size    = r_unlocal_size;
            end
            TX_MY_TWO: begin
                o_src_pending = r_send_valid && r_send_size != '0;
                o_src_queue   = r_send_queue;
                o_src_size    = r_send_size;
            end
            TX_LOCAL: begin
                o_src_pending = r_local_valid && r_local_size != '0;
                o_src_queue   = r_local_queue;
                o_src_size    = r_local_size;
            end
            TX_RELAY: begin
                o_src_pending = i_relay_pending_any;
                o_src_queue   = i_relay_queue;
                o_src_size    = i_relay_size;
            end
            default: ;
        endcase
    end

    assign o_src_remote   = (r_state == TX_UNLOCAL);
    assign o_round_idle   = (r_state == TX_IDLE);
    assign o_relay_active = (r_state == TX_RELAY);

    //////////////////////////////////////////////////////////////////////
    // Forward grant

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_forward_resp  <= 1'b0;
            o_forward_valid <= 1'b0;
        end else begin
            if (o_forward_resp && i_forward_req)
                o_forward_resp <= 1'b0;
            else if (r_state == TX_RECV_TWO && i_forward_req)
                o_forward_resp <= 1'b1;

            if (r_state != TX_RECV_TWO)
                o_forward_valid <= 1'b0;
            else if (i_forward_req)
                o_forward_valid <= 1'b1;
        end
    end

endmodule

//--- tests/tb_rd_ddr_port_ctrl.sv
`timescale 1ns/1ps

`include "ddr_rd_settings.svh"

module tb_rd_ddr_port_ctrl import ddr_rd_pkg::*; ();

    localparam int QN         = `DDR_RD_QUEUE_NUM;
    localparam int SW         = `DDR_RD_SIZE_W;
    localparam int ROUNDS     = 16;
    localparam int WAIT_LIMIT = 600;

    localparam int PH_IDLE   = 0;
    localparam int PH_DELAY  = 1;
    localparam int PH_READY  = 2;
    localparam int PH_FINISH = 3;

    logic         i_clk;
    logic         i_rst;
    logic         i_unlocal_valid;
    byte_cnt_t    i_unlocal_size;
    queue_t       i_unlocal_queue;
    logic         i_send_local2_valid;
    byte_cnt_t    i_send_local2_size;
    queue_t       i_send_local2_queue;
    logic         i_local_direct_valid;
    byte_cnt_t    i_local_direct_size;
    queue_t       i_local_direct_queue;
    logic         i_recv_local2_valid;
    byte_cnt_t    i_recv_local2_size;
    relay_sizes_t i_tx_relay;
    logic         i_tx_relay_valid;
    logic         o_rd_flag;
    queue_t       o_rd_queue;
    byte_cnt_t    o_rd_byte;
    logic         o_rd_byte_valid;
    logic         i_rd_byte_ready;
    logic         i_rd_queue_finish;
    logic         i_forward_req;
    logic         o_forward_resp;
    logic         i_forward_finish;
    logic         o_forward_valid;

    // Expected requests as {flag, queue, size}
    logic [35:0] exp_q[$];
    logic [35:0] held;
    logic [35:0] head;
    logic [31:0] stim_rng;
    logic [31:0] resp_rng;
    logic        prev_valid;
    bit          in_flight;
    int          phase;
    int          cnt;
    int          errors;
    int          timeouts;
    int          requests;

    rd_ddr_port_ctrl DUT (.*);

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // About one size in four is zero
    function automatic byte_cnt_t size_from(input logic [31:0] r);
        if (r[1:0] == 2'd0)
            return '0;
        return byte_cnt_t'(r[15:4]) + 1;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("** Error [%0t ns] %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Requests: %0d, errors: %0d, timeouts: %0d", requests, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out waiting for %s at %0t ns", what, $time);
        finish_run();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory side responder and request monitor

    always @(posedge i_clk) begin
        if (!i_rst) begin
            // Responder steps first so a finish ending here frees the port
            case (phase)
                PH_DELAY: begin
                    cnt = cnt - 1;
                    if (cnt == 0) begin
                        i_rd_byte_ready <= 1'b1;
                        cnt = 4;
                        phase = PH_READY;
                    end
                end
                PH_READY: begin
                    cnt = cnt - 1;
                    if (cnt == 0) begin
                        i_rd_byte_ready   <= 1'b0;
                        i_rd_queue_finish <= 1'b1;
                        cnt = 4;
                        phase = PH_FINISH;
                    end
                end
                PH_FINISH: begin
                    cnt = cnt - 1;
                    if (cnt == 0) begin
                        i_rd_queue_finish <= 1'b0;
                        in_flight = 1'b0;
                        phase = PH_IDLE;
                    end
                end
                default: ;
            endcase
            if (o_rd_byte_valid && !prev_valid) begin
                requests++;
                assert (!in_flight)
                    else log_error("second request before the previous read finished");
                if (exp_q.size() == 0) begin
                    assert (1'b0)
                        else log_error($sformatf("unexpected request for queue %0d", o_rd_queue));
                end else begin
                    head = exp_q.pop_front();
                    assert ({o_rd_flag, o_rd_queue, o_rd_byte} == head)
                        else log_error($sformatf("request %0d/%0d/%0d, expected %0d/%0d/%0d",
                            o_rd_flag, o_rd_queue, o_rd_byte,
                            head[35], head[34:32], head[31:0]));
                end
                held = {o_rd_flag, o_rd_queue, o_rd_byte};
                in_flight = 1'b1;
                resp_rng = xorshift32(resp_rng);
                cnt = 1 + int'(resp_rng[1:0]);
                phase = PH_DELAY;
            end else if (o_rd_byte_valid) begin
                assert ({o_rd_flag, o_rd_queue, o_rd_byte} == held)
                    else log_error("request fields changed while waiting for ready");
            end
            prev_valid = o_rd_byte_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Round stimulus

    task automatic forward_grant();
        int n;
        int hold;
        i_forward_req <= 1'b1;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
            if (n > WAIT_LIMIT)
                report_timeout("the forward response");
        end while (!o_forward_resp);
        assert (o_forward_valid)
            else log_error("forward valid low together with the response");
        i_forward_req <= 1'b0;
        hold = 2 + int'(next_rand() % 4);
        repeat (hold) begin
            @(posedge i_clk);
            assert (!o_forward_resp)
                else log_error("forward response high for more than one cycle");
            assert (o_forward_valid)
                else log_error("forward valid dropped before the forward finish");
        end
        i_forward_finish <= 1'b1;
        @(posedge i_clk);
        i_forward_finish <= 1'b0;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
            if (n > 10)
                report_timeout("forward valid to drop");
        end while (o_forward_valid);
    endtask

    task automatic wait_round_idle();
        int n;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
            if (n > WAIT_LIMIT)
                report_timeout("the round to return to idle");
        end while (!DUT.round_idle || in_flight);
    endtask

    // Mode 1 zeroes the relay vector, mode 3 zeroes every size
    task automatic run_round(input int mode);
        byte_cnt_t    unl_size;
        byte_cnt_t    snd_size;
        byte_cnt_t    loc_size;
        byte_cnt_t    rcv_size;
        queue_t       unl_q;
        queue_t       snd_q;
        queue_t       loc_q;
        relay_sizes_t relay;
        unl_size = (mode == 3) ? '0 : size_from(next_rand());
        snd_size = (mode == 3) ? '0 : size_from(next_rand());
        loc_size = (mode == 3) ? '0 : size_from(next_rand());
        rcv_size = (mode == 3) ? '0 : size_from(next_rand());
        unl_q = queue_t'(next_rand());
        snd_q = queue_t'(next_rand());
        loc_q = queue_t'(next_rand());
        relay = '0;
        for (int i = 0; i < QN; i++)
            relay[i*SW +: SW] = (mode == 1 || mode == 3) ? '0 : size_from(next_rand());

        // Only the unlocal source reads for a remote port
        if (unl_size != '0)
            exp_q.push_back({1'b1, unl_q, unl_size});
        if (snd_size != '0)
            exp_q.push_back({1'b0, snd_q, snd_size});
        if (loc_size != '0)
            exp_q.push_back({1'b0, loc_q, loc_size});
        for (int i = 0; i < QN; i++)
            if (relay[i*SW +: SW] != '0)
                exp_q.push_back({1'b0, queue_t'(i), relay[i*SW +: SW]});

        @(posedge i_clk);
        i_unlocal_valid <= 1'b1;
        i_unlocal_size  <= unl_size;
        i_unlocal_queue <= unl_q;
        @(posedge i_clk);
        i_unlocal_valid      <= 1'b0;
        i_send_local2_valid  <= 1'b1;
        i_send_local2_size   <= snd_size;
        i_send_local2_queue  <= snd_q;
        i_local_direct_valid <= 1'b1;
        i_local_direct_size  <= loc_size;
        i_local_direct_queue <= loc_q;
        i_recv_local2_valid  <= 1'b1;
        i_recv_local2_size   <= rcv_size;
        i_tx_relay           <= relay;
        i_tx_relay_valid     <= 1'b1;
        @(posedge i_clk);
        i_send_local2_valid  <= 1'b0;
        i_local_direct_valid <= 1'b0;
        i_recv_local2_valid  <= 1'b0;
        i_tx_relay_valid     <= 1'b0;
        if (rcv_size != '0)
            forward_grant();
        wait_round_idle();
        assert (exp_q.size() == 0)
            else log_error($sformatf("%0d expected requests never issued", exp_q.size()));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_unlocal_valid = 1'b0;
        i_unlocal_size = '0;
        i_unlocal_queue = '0;
        i_send_local2_valid = 1'b0;
        i_send_local2_size = '0;
        i_send_local2_queue = '0;
        i_local_direct_valid = 1'b0;
        i_local_direct_size = '0;
        i_local_direct_queue = '0;
        i_recv_local2_valid = 1'b0;
        i_recv_local2_size = '0;
        i_tx_relay = '0;
        i_tx_relay_valid = 1'b0;
        i_rd_byte_ready = 1'b0;
        i_rd_queue_finish = 1'b0;
        i_forward_req = 1'b0;
        i_forward_finish = 1'b0;
        stim_rng = 32'h820f;
        resp_rng = xorshift32(32'h820f);
        prev_valid = 1'b0;
        in_flight = 1'b0;
        phase = PH_IDLE;
        cnt = 0;
        errors = 0;
        timeouts = 0;
        requests = 0;

        for (int c = 0; c < 18; c++) begin
            @(posedge i_clk);
            if (c == 15)
                i_rst <= 1'b0;
            if (c > 0) begin
                assert (!o_rd_byte_valid && !o_rd_flag && !o_forward_resp && !o_forward_valid)
                    else log_error("control output active during or just after reset");
            end
        end

        for (int r = 0; r < ROUNDS; r++) begin
            run_round(r % 4);
            repeat (8) @(posedge i_clk);
        end
        finish_run();
    end

endmodule

//--- vlog.f
+incdir+logic
logic/ddr_rd_pkg.sv
logic/edge_sync.sv
logic/relay_queue_tracker.sv
logic/tx_round_fsm.sv
logic/rd_req_issuer.sv
logic/rd_ddr_port_ctrl.sv
tests/tb_rd_ddr_port_ctrl.sv
